// File: build.f
hw/lsq_pkg.sv
hw/data_mem.sv
hw/ls_queue.sv
hw/ls_unit.sv
hw/ls_top.sv
bench/ls_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module ls_top_tb -f build.f -o ls_top_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ls_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
exit 1

// File: bench/ls_top_tb.sv
`timescale 1ns/1ps

module ls_top_tb;

   localparam int QUEUE_DEPTH   = 4;
   localparam int MEM_ADDR_BITS = 8;
   localparam int CLK_PERIOD    = 20;
   localparam int LOAD_WAIT     = 40;
   // every store of the fill takes about two cycles in the unit
   localparam int FILL_CYCLES   = 3 * (2 ** MEM_ADDR_BITS);
   // reset, random pairs, wakeup, full queue, priority, chained loads
   localparam int TEST_CYCLES   = 10 + 8 * (LOAD_WAIT + 4) + (LOAD_WAIT + 10) +
                                  QUEUE_DEPTH * (2 * LOAD_WAIT) + (LOAD_WAIT + 12) +
                                  2 * LOAD_WAIT;

   logic                  clk;
   logic                  rst;
   lsq_pkg::ls_dispatch_t dispatch;
   logic                  dispatch_en;
   logic                  dispatch_ready;
   lsq_pkg::cdb_t         ext_cdb;
   lsq_pkg::cdb_t         cdb;

   // word-level image of what the data memory should hold
   logic [31:0] model_mem [2 ** MEM_ADDR_BITS];
   logic [31:0] rng_state;
   int          pass_count;
   int          fail_count;

   ls_top #(
      .QUEUE_DEPTH  (QUEUE_DEPTH),
      .MEM_ADDR_BITS(MEM_ADDR_BITS)
   ) DUT (
      .clk           (clk),
      .rst           (rst),
      .dispatch      (dispatch),
      .dispatch_en   (dispatch_en),
      .dispatch_ready(dispatch_ready),
      .ext_cdb       (ext_cdb),
      .cdb           (cdb)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // the word index is taken from the base plus the sign-extended offset
   function automatic logic [MEM_ADDR_BITS-1:0] word_of(input logic [31:0] base,
                                                        input logic [15:0] off);
      logic [31:0] ea;
      ea = base + {{16{off[15]}}, off};
      return ea[MEM_ADDR_BITS+1:2];
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_count++;
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
      end else begin
         pass_count++;
      end
   endtask

   task automatic check_cdb(input string name, input lsq_pkg::cdb_t exp,
                            input lsq_pkg::cdb_t act);
      if (act !== exp) begin
         fail_count++;
         $display("MISMATCH %s expected v=%b tag=%0d data=%h actual v=%b tag=%0d data=%h",
                  name, exp.valid, exp.tag, exp.data, act.valid, act.tag, act.data);
      end else begin
         pass_count++;
      end
   endtask

   task automatic report_test(input string name, input int mark);
      if (fail_count == mark) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d failed checks", name, fail_count - mark);
      end
   endtask

   // holds the instruction until the queue has room, then drives it for one edge
   task automatic push(input lsq_pkg::ls_dispatch_t d);
      int waited;
      waited = 0;
      while (!dispatch_ready && waited < LOAD_WAIT) begin
         step();
         waited++;
      end
      if (!dispatch_ready) begin
         fail_count++;
         $display("queue never had room, an instruction was not dispatched");
      end else begin
         dispatch    = d;
         dispatch_en = 1'b1;
         step();
         dispatch_en = 1'b0;
      end
   endtask

   // the model is updated in program order, which is also the order stores reach memory
   task automatic send_store(input logic [31:0] base, input logic [15:0] off,
                             input logic [31:0] data, input logic [5:0] data_tag,
                             input logic data_valid);
      lsq_pkg::ls_dispatch_t d;
      d          = '0;
      d.op       = lsq_pkg::LS_STORE;
      d.offset   = off;
      d.rs_data  = base;
      d.rs_valid = 1'b1;
      d.rt_tag   = data_tag;
      d.rt_data  = data;
      d.rt_valid = data_valid;
      model_mem[word_of(base, off)] = data;
      push(d);
   endtask

   task automatic send_load(input logic [5:0] rd, input logic [31:0] base,
                            input logic [15:0] off, input logic [5:0] base_tag,
                            input logic base_valid);
      lsq_pkg::ls_dispatch_t d;
      d          = '0;
      d.op       = lsq_pkg::LS_LOAD;
      d.offset   = off;
      d.rd_tag   = rd;
      d.rs_tag   = base_tag;
      d.rs_data  = base;
      d.rs_valid = base_valid;
      d.rt_valid = 1'b1;
      push(d);
   endtask

   task automatic ext_broadcast(input logic [5:0] tag, input logic [31:0] data);
      ext_cdb.valid = 1'b1;
      ext_cdb.tag   = tag;
      ext_cdb.data  = data;
      step();
      ext_cdb = '0;
   endtask

   // waits for the next load result in a bus cycle it owns, checks it, then lets that edge pass
   task automatic wait_load(input string name, input logic [5:0] tag, input logic [31:0] data);
      lsq_pkg::cdb_t exp;
      int            cycles;
      logic          seen;
      exp       = '0;
      exp.valid = 1'b1;
      exp.tag   = tag;
      exp.data  = data;
      seen      = 1'b0;
      cycles    = 0;
      while (!seen && cycles < LOAD_WAIT) begin
         @(negedge clk);
         seen = cdb.valid && !ext_cdb.valid;
         cycles++;
      end
      if (seen) begin
         check_cdb(name, exp, cdb);
      end else begin
         fail_count++;
         $display("%s: no load result with tag %0d appeared on the bus", name, tag);
      end
      step();
   endtask

   task automatic test_reset_idle();
      int mark;
      mark = fail_count;
      check_bit("reset_ready", 1'b1, dispatch_ready);
      repeat (5) begin
         @(negedge clk);
         check_bit("reset_cdb_idle", 1'b0, cdb.valid);
      end
      step();
      report_test("reset_idle", mark);
   endtask

   // every word gets a value built from its full address, so no load reads an unwritten word
   task automatic fill_memory();
      logic [31:0] a;
      for (int i = 0; i < 2 ** MEM_ADDR_BITS; i++) begin
         a = 32'(i);
         send_store(a << 2, 16'h0000, (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f, 6'd0, 1'b1);
      end
   endtask

   task automatic test_random_rw();
      int          mark;
      logic [31:0] r;
      logic [31:0] base;
      logic [31:0] base2;
      logic [15:0] off;
      logic [15:0] off2;
      mark = fail_count;
      for (int i = 0; i < 8; i++) begin
         base    = next_random();
         r       = next_random();
         off     = r[15:0];
         off2    = r[31:16];
         // alternate signs so both offset directions are covered
         off[15]  = i[0];
         off2[15] = ~i[0];
         send_store(base, off, next_random(), 6'd0, 1'b1);
         // the load reaches the same word through a different base and offset split
         base2 = base + {{16{off[15]}}, off} - {{16{off2[15]}}, off2};
         send_load(6'(i + 1), base2, off2, 6'd0, 1'b1);
         wait_load("random_rw", 6'(i + 1), model_mem[word_of(base2, off2)]);
      end
      report_test("random_rw", mark);
   endtask

   task automatic test_wakeup();
      int          mark;
      logic [31:0] base;
      logic [15:0] off;
      mark = fail_count;
      base = next_random();
      off  = 16'hfff8;
      send_load(6'd12, 32'h0, off, 6'd11, 1'b0);
      repeat (5) begin
         @(negedge clk);
         check_bit("wakeup_hold", 1'b0, cdb.valid);
      end
      step();
      ext_broadcast(6'd11, base);
      wait_load("wakeup_load", 6'd12, model_mem[word_of(base, off)]);
      report_test("wakeup", mark);
   endtask

   task automatic test_full_queue();
      int          mark;
      logic [31:0] fbase [QUEUE_DEPTH];
      logic [31:0] fdata [QUEUE_DEPTH];
      mark = fail_count;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         // odd stores share the word of the store before them
         if (i[0]) begin
            fbase[i] = fbase[i - 1];
         end else begin
            fbase[i] = next_random();
         end
         fdata[i] = next_random();
         send_store(fbase[i], 16'h0000, fdata[i], 6'(20 + i), 1'b0);
      end
      check_bit("full_ready_low", 1'b0, dispatch_ready);
      // data arrives youngest first, so each shared word ends up right only with in-order issue
      for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
         ext_broadcast(6'(20 + i), fdata[i]);
      end
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         send_load(6'(30 + i), fbase[i], 16'h0000, 6'd0, 1'b1);
         wait_load("full_readback", 6'(30 + i), model_mem[word_of(fbase[i], 16'h0000)]);
      end
      report_test("full_queue", mark);
   endtask

   task automatic test_bus_priority();
      int            mark;
      lsq_pkg::cdb_t ext;
      logic [31:0]   base;
      mark = fail_count;
      base = next_random();
      send_load(6'd45, base, 16'h0010, 6'd0, 1'b1);
      // external traffic covers the cycles in which the load would broadcast
      for (int i = 0; i < 6; i++) begin
         ext.valid = 1'b1;
         ext.tag   = 6'd40;
         ext.data  = next_random();
         ext_cdb   = ext;
         @(negedge clk);
         check_cdb("priority_ext", ext, cdb);
         step();
      end
      ext_cdb = '0;
      wait_load("priority_load", 6'd45, model_mem[word_of(base, 16'h0010)]);
      repeat (3) begin
         @(negedge clk);
         check_bit("priority_once", 1'b0, cdb.valid);
      end
      step();
      report_test("bus_priority", mark);
   endtask

   task automatic test_chained_loads();
      int          mark;
      logic [31:0] r;
      logic [31:0] base;
      logic [31:0] v1;
      mark = fail_count;
      base = next_random();
      r    = next_random();
      v1   = model_mem[word_of(base, r[15:0])];
      send_load(6'd50, base, r[15:0], 6'd0, 1'b1);
      // the second base comes straight from the first load's broadcast
      send_load(6'd51, 32'h0, r[31:16], 6'd50, 1'b0);
      wait_load("chain_first", 6'd50, v1);
      wait_load("chain_second", 6'd51, model_mem[word_of(v1, r[31:16])]);
      report_test("chained_loads", mark);
   endtask

   initial begin
      #(2 * (FILL_CYCLES + TEST_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      dispatch    = '0;
      dispatch_en = 1'b0;
      ext_cdb     = '0;
      rng_state   = 32'hd690_39f7;
      pass_count  = 0;
      fail_count  = 0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset_idle();
      fill_memory();
      test_random_rw();
      test_wakeup();
      test_full_queue();
      test_bus_priority();
      test_chained_loads();
      $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: hw/ls_top.sv
`timescale 1ns/1ps

module ls_top #(
   parameter int QUEUE_DEPTH   = 4,
   parameter int MEM_ADDR_BITS = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  lsq_pkg::ls_dispatch_t dispatch,
   input  logic                  dispatch_en,
   output logic                  dispatch_ready,
   input  lsq_pkg::cdb_t         ext_cdb,
   output lsq_pkg::cdb_t         cdb
);

   lsq_pkg::ls_issue_t         issue;
   logic                       issue_ready;
   logic                       issue_done;
   logic                       mem_we;
   logic [MEM_ADDR_BITS-1:0]   mem_addr;
   logic [lsq_pkg::DATA_W-1:0] mem_wdata;
   logic [lsq_pkg::DATA_W-1:0] mem_rdata;
   lsq_pkg::cdb_t              load_cdb;
   logic                       load_grant;

   // external producers always win, a load result waits for a free cycle
   assign load_grant = ~ext_cdb.valid;
   assign cdb        = ext_cdb.valid ? ext_cdb : load_cdb;

   ls_queue #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) u_queue (
      .clk           (clk),
      .rst           (rst),
      .dispatch      (dispatch),
      .dispatch_en   (dispatch_en),
      .dispatch_ready(dispatch_ready),
      .cdb           (cdb),
      .issue         (issue),
      .issue_ready   (issue_ready),
      .issue_done    (issue_done)
   );

   ls_unit #(
      .MEM_ADDR_BITS(MEM_ADDR_BITS)
   ) u_unit (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .issue_ready(issue_ready),
      .issue_done (issue_done),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .load_cdb   (load_cdb),
      .load_grant (load_grant)
   );

   data_mem #(
      .MEM_ADDR_BITS(MEM_ADDR_BITS)
   ) u_mem (
      .clk  (clk),
      .we   (mem_we),
      .addr (mem_addr),
      .wdata(mem_wdata),
      .rdata(mem_rdata)
   );

endmodule

// File: hw/ls_unit.sv
`timescale 1ns/1ps

module ls_unit #(
   parameter int MEM_ADDR_BITS = 8
) (
   input  logic                       clk,
   input  logic                       rst,
   input  lsq_pkg::ls_issue_t         issue,
   input  logic                       issue_ready,
   output logic                       issue_done,
   output logic                       mem_we,
   output logic [MEM_ADDR_BITS-1:0]   mem_addr,
   output logic [lsq_pkg::DATA_W-1:0] mem_wdata,
   input  logic [lsq_pkg::DATA_W-1:0] mem_rdata,
   output lsq_pkg::cdb_t              load_cdb,
   input  logic                       load_grant
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      BROADCAST
   } state_e;

   state_e             state_q;
   state_e             state_d;
   lsq_pkg::ls_issue_t inst_q;

   // the unit takes the head whenever it has nothing in flight
   assign issue_done = (state_q == IDLE) & issue_ready;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (issue_done) begin
               state_d = ACCESS;
            end
         end
         ACCESS: begin
            // a store is finished once its write goes out
            if (inst_q.op == lsq_pkg::LS_LOAD) begin
               state_d = BROADCAST;
            end else begin
               state_d = IDLE;
            end
         end
         BROADCAST: begin
            // stay here while other producers hold the bus
            if (load_grant) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_done) begin
         inst_q <= issue;
      end
   end

   // byte address to word address, the two low bits select a byte and are dropped
   assign mem_addr  = inst_q.addr[MEM_ADDR_BITS+1:2];
   assign mem_wdata = inst_q.data;
   assign mem_we    = (state_q == ACCESS) & (inst_q.op == lsq_pkg::LS_STORE);

   // the read launched in ACCESS lands in cycle 2
   // the address stays frozen and nothing writes while broadcasting, so the
   // memory read register keeps holding the loaded word until the grant
   assign load_cdb.valid = (state_q == BROADCAST);
   assign load_cdb.tag   = inst_q.rd_tag;
   assign load_cdb.data  = mem_rdata;

endmodule

// File: hw/ls_queue.sv
`timescale 1ns/1ps

module ls_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  lsq_pkg::ls_dispatch_t dispatch,
   input  logic                  dispatch_en,
   output logic                  dispatch_ready,
   input  lsq_pkg::cdb_t         cdb,
   output lsq_pkg::ls_issue_t    issue,
   output logic                  issue_ready,
   input  logic                  issue_done
);

   // an entry is the dispatched instruction plus its effective address
   typedef struct packed {
      lsq_pkg::ls_dispatch_t         inst;
      logic [lsq_pkg::DATA_W-1:0]    addr;
   } entry_t;

   // slot 0 is the oldest entry, valid slots are always packed from slot 0 upwards
   entry_t                 ent_q [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] vld_q;

   // candidates after the bus snoop, index QUEUE_DEPTH is the dispatch input
   // acting as a virtual entry sitting above the top slot
   entry_t                 cand  [QUEUE_DEPTH+1];
   entry_t                 ent_d [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] vld_d;
   entry_t                 dispatch_entry;
   logic [QUEUE_DEPTH:0]   vld_up;
   logic [QUEUE_DEPTH:0]   vld_dn;
   logic                   pop;
   logic                   accept;

   // base plus the sign-extended 16-bit offset
   function automatic logic [lsq_pkg::DATA_W-1:0] eff_addr(
      input logic [lsq_pkg::DATA_W-1:0]   base,
      input logic [lsq_pkg::OFFSET_W-1:0] offset
   );
      eff_addr = base + {{(lsq_pkg::DATA_W-lsq_pkg::OFFSET_W){offset[lsq_pkg::OFFSET_W-1]}},
                         offset};
   endfunction

   // an operand picks up bus data only while it is still waiting on its tag
   function automatic entry_t wakeup(input entry_t e, input lsq_pkg::cdb_t bus);
      entry_t r;
      r = e;
      if (bus.valid && !e.inst.rs_valid && bus.tag == e.inst.rs_tag) begin
         r.inst.rs_data  = bus.data;
         r.inst.rs_valid = 1'b1;
         // a fresh base means a fresh address
         r.addr          = eff_addr(bus.data, e.inst.offset);
      end
      if (bus.valid && !e.inst.rt_valid && bus.tag == e.inst.rt_tag) begin
         r.inst.rt_data  = bus.data;
         r.inst.rt_valid = 1'b1;
      end
      return r;
   endfunction

   assign dispatch_entry.inst = dispatch;
   assign dispatch_entry.addr = eff_addr(dispatch.rs_data, dispatch.offset);

   // only the head is ever offered, loads and stores leave in program order
   assign issue_ready = vld_q[0] & ent_q[0].inst.rs_valid &
                        (ent_q[0].inst.rt_valid | (ent_q[0].inst.op == lsq_pkg::LS_LOAD));

   assign issue.op     = ent_q[0].inst.op;
   assign issue.rd_tag = ent_q[0].inst.rd_tag;
   assign issue.addr   = ent_q[0].addr;
   assign issue.data   = ent_q[0].inst.rt_data;

   assign pop = issue_done & issue_ready;

   // full only when every slot holds an entry and nothing leaves this cycle
   assign dispatch_ready = ~(&vld_q & ~pop);
   assign accept         = dispatch_en & dispatch_ready;

   // valid of the slot above, the top slot sees nothing above it
   assign vld_up = {1'b0, vld_q};
   // valid of the slot below, slot 0 has the floor below it
   assign vld_dn = {vld_q, 1'b1};

   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         cand[i] = wakeup(ent_q[i], cdb);
      end
      // the incoming instruction also snoops, so a same-cycle broadcast is not lost
      cand[QUEUE_DEPTH] = wakeup(dispatch_entry, cdb);
   end

   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (pop) begin
            if (vld_up[i+1]) begin
               // the head leaves and everything above moves down one slot
               ent_d[i] = cand[i+1];
               vld_d[i] = 1'b1;
            end else begin
               // the topmost occupied slot frees up, the new entry can land in it
               ent_d[i] = cand[QUEUE_DEPTH];
               vld_d[i] = vld_q[i] & accept;
            end
         end else if (vld_q[i]) begin
            ent_d[i] = cand[i];
            vld_d[i] = 1'b1;
         end else begin
            // the first free slot above the occupied ones takes the new entry
            ent_d[i] = cand[QUEUE_DEPTH];
            vld_d[i] = vld_dn[i] & accept;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= '0;
      end else begin
         vld_q <= vld_d;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         ent_q[i] <= ent_d[i];
      end
   end

endmodule

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
   parameter int MEM_ADDR_BITS = 8
) (
   input  logic                       clk,
   input  logic                       we,
   input  logic [MEM_ADDR_BITS-1:0]   addr,
   input  logic [lsq_pkg::DATA_W-1:0] wdata,
   output logic [lsq_pkg::DATA_W-1:0] rdata
);

   localparam int WORDS = 2 ** MEM_ADDR_BITS;

   // contents are undefined until written
   logic [lsq_pkg::DATA_W-1:0] mem [WORDS];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // registered read, the word shows up one cycle after its address
   // a read and a write to the same word in one cycle return the old value
   always_ff @(posedge clk) begin
      rdata <= mem[addr];
   end

endmodule

// File: hw/lsq_pkg.sv
package lsq_pkg;

   // rename tag width, tag 0 marks an operand with no producer and never goes on the bus
   localparam int TAG_W    = 6;
   localparam int DATA_W   = 32;
   localparam int OFFSET_W = 16;

   // a load waits only on its base, a store also waits on the data it writes
   typedef enum logic {
      LS_STORE = 1'b0,
      LS_LOAD  = 1'b1
   } ls_op_e;

   // one instruction as the dispatch unit hands it over
   typedef struct packed {
      ls_op_e              op;
      logic [OFFSET_W-1:0] offset;
      logic [TAG_W-1:0]    rd_tag;
      logic [TAG_W-1:0]    rs_tag;
      logic [DATA_W-1:0]   rs_data;
      logic                rs_valid;
      logic [TAG_W-1:0]    rt_tag;
      logic [DATA_W-1:0]   rt_data;
      logic                rt_valid;
   } ls_dispatch_t;

   // head of the queue with the address already formed
   typedef struct packed {
      ls_op_e            op;
      logic [TAG_W-1:0]  rd_tag;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } ls_issue_t;

   typedef struct packed {
      logic              valid;
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] data;
   } cdb_t;

endpackage
